//--- design/controlStore_settings.svh
/*
   control store settings
   microword geometry, store depth and field positions
*/
`ifndef CONTROLSTORE_SETTINGS_SVH
`define CONTROLSTORE_SETTINGS_SVH

// full microword width
`define CS_WORD_W 64
// control store address width and depth
`define CS_ADDR_W 8
`define CS_DEPTH 256
// internal data bus width, one slice of the microword
`define CS_SLICE_W 16

// field positions inside a microword
`define CS_NEXT_LSB 0
`define CS_SEQOP_LSB 8
// control bits sit above the 2-bit sequencing opcode
`define CS_CTRL_LSB (`CS_SEQOP_LSB + 2)
`define CS_CTRL_W (`CS_WORD_W - `CS_CTRL_LSB)

`endif

//--- design/csPkg.sv
/*
   control store package
   sequencing opcode type shared by the sequencer and the MIR
*/
`default_nettype none

package csPkg;

   // sequencing opcodes held in bits 9:8 of a microword
   // seqNext       uPC + 1
   // seqJump       nextAddr
   // seqJumpIfFlag nextAddr when flag is set, else uPC + 1
   // seqHold       uPC unchanged
   typedef enum logic [1:0] {
      seqNext       = 2'd0,
      seqJump       = 2'd1,
      seqJumpIfFlag = 2'd2,
      seqHold       = 2'd3
   } seqOpT;

endpackage

`default_nettype wire

//--- design/microSequencer.sv
/*
   microsequencer, pipeline stage 1
   keeps the microprogram counter and picks the next address
*/
`timescale 1ns/1ns
`default_nettype none
`include "controlStore_settings.svh"

module microSequencer (
   input  wire logic                  clk,
   input  wire logic                  rstN,
   // host control that hands uPC to the host while run is low
   input  wire logic                  run,
   input  wire logic [`CS_ADDR_W-1:0] hostAddr,
   // branch condition from the CPU
   input  wire logic                  flag,
   // sequencing fields decoded by the MIR
   input  wire csPkg::seqOpT          seqOp,
   input  wire logic [`CS_ADDR_W-1:0] nextAddr,
   output logic      [`CS_ADDR_W-1:0] uPC
);

   logic [`CS_ADDR_W-1:0] uPCInc;
   logic [`CS_ADDR_W-1:0] uPCNext;

   // increment wraps at the top of the store
   assign uPCInc = uPC + `CS_ADDR_W'(1);

   // next address selection
   always_comb begin
      if (!run) begin
         // host owns the address while stopped
         uPCNext = hostAddr;
      end else begin
         case (seqOp)
            csPkg::seqNext: begin
               uPCNext = uPCInc;
            end
            csPkg::seqJump: begin
               uPCNext = nextAddr;
            end
            csPkg::seqJumpIfFlag: begin
               // branch taken only on flag
               uPCNext = flag ? nextAddr : uPCInc;
            end
            csPkg::seqHold: begin
               uPCNext = uPC;
            end
            default: begin
               uPCNext = uPCInc;
            end
         endcase
      end
   end

   // microprogram counter
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         uPC <= '0;
      end else begin
         uPC <= uPCNext;
      end
   end

endmodule

`default_nettype wire

//--- design/controlStoreRam.sv
/*
   writable control store, pipeline stage 2
   256 x 64 microword RAM with a registered read-first port
*/
`timescale 1ns/1ns
`default_nettype none
`include "controlStore_settings.svh"

module controlStoreRam (
   input  wire logic                  clk,
   input  wire logic                  rstN,
   input  wire logic                  run,
   // host commit port
   input  wire logic                  wrEn,
   input  wire logic [`CS_ADDR_W-1:0] wrAddr,
   input  wire logic [`CS_WORD_W-1:0] wrData,
   // sequencer read port
   input  wire logic [`CS_ADDR_W-1:0] rdAddr,
   output logic      [`CS_WORD_W-1:0] rdData
);

   logic [`CS_WORD_W-1:0] mem [0:`CS_DEPTH-1];
   logic                  wrGo;

   // store is only writable while the sequencer is stopped
   assign wrGo = wrEn && !run;

   // storage array
   always_ff @(posedge clk) begin
      if (wrGo) begin
         mem[wrAddr] <= wrData;
      end
   end

   // read register
   // same-edge write to rdAddr still returns the old word
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         rdData <= '0;
      end else begin
         rdData <= mem[rdAddr];
      end
   end

endmodule

`default_nettype wire

//--- design/microWordRegister.sv
/*
   microinstruction register, pipeline stage 3
   holds the word read from the store and splits out its fields
*/
`timescale 1ns/1ns
`default_nettype none
`include "controlStore_settings.svh"

module microWordRegister (
   input  wire logic                  clk,
   input  wire logic                  rstN,
   // word from the control store read port
   input  wire logic [`CS_WORD_W-1:0] rdData,
   // whole word for host read-back
   output logic      [`CS_WORD_W-1:0] mirWord,
   // sequencing fields back to stage 1
   output csPkg::seqOpT               seqOp,
   output logic      [`CS_ADDR_W-1:0] nextAddr,
   // control field seen by the rest of the CPU
   output logic      [`CS_CTRL_W-1:0] ctrlBits
);

   // capture every edge, no enable
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         mirWord <= '0;
      end else begin
         mirWord <= rdData;
      end
   end

   // field decode
   // a cleared MIR reads as seqNext
   assign seqOp    = csPkg::seqOpT'(mirWord[`CS_SEQOP_LSB +: $bits(csPkg::seqOpT)]);
   assign nextAddr = mirWord[`CS_NEXT_LSB +: `CS_ADDR_W];
   assign ctrlBits = mirWord[`CS_CTRL_LSB +: `CS_CTRL_W];

endmodule

`default_nettype wire

//--- design/csTransceiver.sv
/*
   control store transceiver
   moves 16-bit slices between the internal data bus and the microword
*/
`timescale 1ns/1ns
`default_nettype none
`include "controlStore_settings.svh"

module csTransceiver (
   input  wire logic                   clk,
   input  wire logic                   rstN,
   // internal data bus
   input  wire logic [`CS_SLICE_W-1:0] idbIn,
   output logic      [`CS_SLICE_W-1:0] idbOut,
   // MIR contents for read-back
   input  wire logic [`CS_WORD_W-1:0]  mirWord,
   // staging word waiting for a commit
   output logic      [`CS_WORD_W-1:0]  stagedWord,
   // active-low strobes and slice enables
   input  wire logic                   wcsN,
   input  wire logic                   ecslN,
   input  wire logic [3:0]             ewN
);

   logic [1:0] sliceSel;
   logic       sliceValid;

   // priority select, lowest low enable wins
   always_comb begin
      sliceValid = 1'b1;
      if (!ewN[0]) begin
         sliceSel = 2'd0;
      end else if (!ewN[1]) begin
         sliceSel = 2'd1;
      end else if (!ewN[2]) begin
         sliceSel = 2'd2;
      end else if (!ewN[3]) begin
         sliceSel = 2'd3;
      end else begin
         // nothing enabled
         sliceSel   = 2'd0;
         sliceValid = 1'b0;
      end
   end

   // bus to staging word, only the chosen slice changes
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         stagedWord <= '0;
      end else if (!wcsN && sliceValid) begin
         stagedWord[sliceSel*`CS_SLICE_W +: `CS_SLICE_W] <= idbIn;
      end
   end

   // MIR slice to bus
   // driven only in read direction with the output enable low
   assign idbOut = (wcsN && !ecslN && sliceValid) ?
                   mirWord[sliceSel*`CS_SLICE_W +: `CS_SLICE_W] : '0;

endmodule

`default_nettype wire

//--- design/controlStoreTop.sv
/*
   control store top
   sequencer, writable store, MIR and bus transceiver
*/
`timescale 1ns/1ns
`default_nettype none
`include "controlStore_settings.svh"

module controlStoreTop (
   input  wire logic                   clk,
   input  wire logic                   rstN,
   // host side
   input  wire logic                   run,
   input  wire logic [`CS_ADDR_W-1:0]  hostAddr,
   input  wire logic [`CS_SLICE_W-1:0] idbIn,
   input  wire logic                   wcsN,
   input  wire logic [3:0]             ewN,
   input  wire logic                   ecslN,
   input  wire logic                   wcsCommit,
   output logic      [`CS_SLICE_W-1:0] idbOut,
   // CPU side
   input  wire logic                   flag,
   output logic      [`CS_ADDR_W-1:0]  uPC,
   output logic      [`CS_CTRL_W-1:0]  ctrlBits
);

   logic [`CS_WORD_W-1:0] rdData;
   logic [`CS_WORD_W-1:0] mirWord;
   logic [`CS_WORD_W-1:0] stagedWord;
   logic [`CS_ADDR_W-1:0] nextAddr;
   csPkg::seqOpT          seqOp;

   // stage 1
   microSequencer uSeq (
      .clk      (clk),
      .rstN     (rstN),
      .run      (run),
      .hostAddr (hostAddr),
      .flag     (flag),
      .seqOp    (seqOp),
      .nextAddr (nextAddr),
      .uPC      (uPC)
   );

   // stage 2
   // commit qualified with run inside the RAM
   controlStoreRam uRam (
      .clk    (clk),
      .rstN   (rstN),
      .run    (run),
      .wrEn   (wcsCommit),
      .wrAddr (hostAddr),
      .wrData (stagedWord),
      .rdAddr (uPC),
      .rdData (rdData)
   );

   // stage 3
   microWordRegister uMir (
      .clk      (clk),
      .rstN     (rstN),
      .rdData   (rdData),
      .mirWord  (mirWord),
      .seqOp    (seqOp),
      .nextAddr (nextAddr),
      .ctrlBits (ctrlBits)
   );

   // host slice access
   csTransceiver uTcv (
      .clk        (clk),
      .rstN       (rstN),
      .idbIn      (idbIn),
      .idbOut     (idbOut),
      .mirWord    (mirWord),
      .stagedWord (stagedWord),
      .wcsN       (wcsN),
      .ecslN      (ecslN),
      .ewN        (ewN)
   );

endmodule

`default_nettype wire

//--- verif/controlStoreTb.sv
/*
   control store testbench
   slice writes, commits, read-back and sequencing checked against a shadow model
*/
`timescale 1ns/1ns
`default_nettype none
`include "controlStore_settings.svh"

module controlStoreTb;

   localparam int CLK_PERIOD = 20;
   localparam int TEST_WORDS = 16;
   localparam int RUN_CYCLES = 300;
   localparam int HOLD_CYCLES = 10;
   // 6 cycles per word write and 7 per read-back plus run time and slack
   localparam int LIMIT_CYCLES = (TEST_WORDS + `CS_DEPTH + 4) * 6 + (TEST_WORDS + 4) * 7
                                 + RUN_CYCLES + HOLD_CYCLES + 100;

   logic                   clk = 1'b0;
   logic                   rstN, run, wcsN, ecslN, wcsCommit, flag;
   logic [`CS_ADDR_W-1:0]  hostAddr;
   logic [`CS_SLICE_W-1:0] idbIn;
   logic [3:0]             ewN;
   logic [`CS_SLICE_W-1:0] idbOut;
   logic [`CS_ADDR_W-1:0]  uPC;
   logic [`CS_CTRL_W-1:0]  ctrlBits;

   // shadow model of store, staging word and the two pipeline registers
   logic [`CS_WORD_W-1:0]  shadowMem [0:`CS_DEPTH-1];
   bit                     shadowKnown [0:`CS_DEPTH-1];
   logic [`CS_WORD_W-1:0]  mStaged = '0, mRd = '0, mMir = '0;
   bit                     mRdKnown = 1'b1, mMirKnown = 1'b1;
   logic [`CS_ADDR_W-1:0]  mUpc = '0, holdUpc = '0;
   bit                     holdArmed = 1'b0;
   logic [31:0]            lfsr = 32'h0d71_d51d;
   int                     errCount = 0, checkCount = 0, holdSeen = 0;
   logic [`CS_ADDR_W-1:0]  testAddr [0:TEST_WORDS-1];
   logic [`CS_WORD_W-1:0]  testWord [0:TEST_WORDS-1];

   controlStoreTop uut (
      .clk (clk), .rstN (rstN), .run (run), .hostAddr (hostAddr), .idbIn (idbIn),
      .wcsN (wcsN), .ewN (ewN), .ecslN (ecslN), .wcsCommit (wcsCommit),
      .idbOut (idbOut), .flag (flag), .uPC (uPC), .ctrlBits (ctrlBits)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // galois step with taps x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] galoisStep(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // one step per bit taken
   task automatic takeBits(input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[62:0], lfsr[0]};
         lfsr = galoisStep(lfsr);
      end
   endtask

   // lowest low enable picks the slice or -1 when none is low
   function automatic int lowSlice(input logic [3:0] en);
      for (int i = 0; i < 4; i++) begin
         if (!en[i]) return i;
      end
      return -1;
   endfunction

   // next microprogram address from the opcode table
   function automatic logic [7:0] nextUpc(input logic [1:0] op, input logic [7:0] target,
                                          input logic flg, input logic [7:0] pc);
      if (op == csPkg::seqJump || (op == csPkg::seqJumpIfFlag && flg)) return target;
      if (op == csPkg::seqHold) return pc;
      return pc + 8'd1;
   endfunction

   task automatic valueError(input string what, input logic [63:0] exp,
                             input logic [63:0] got);
      errCount++;
      $display("** Error at %0t ns: %s expected %h, got %h", $time, what, exp, got);
   endtask

   // model steps on the same edge as the DUT and sees pre-edge inputs
   always @(posedge clk) begin
      int sel;
      sel = lowSlice(ewN);
      if (!rstN) begin
         mStaged <= '0;
         mRd <= '0;
         mMir <= '0;
         mRdKnown <= 1'b1;
         mMirKnown <= 1'b1;
         mUpc <= '0;
      end else begin
         if (!wcsN && sel >= 0) mStaged[sel*`CS_SLICE_W +: `CS_SLICE_W] <= idbIn;
         if (wcsCommit && !run) begin
            shadowMem[hostAddr] <= mStaged;
            shadowKnown[hostAddr] <= 1'b1;
         end
         // read-first returns the old word on a same-edge write
         mRd <= shadowMem[mUpc];
         mRdKnown <= shadowKnown[mUpc];
         mMir <= mRd;
         mMirKnown <= mRdKnown;
         mUpc <= run ? nextUpc(mMir[`CS_SEQOP_LSB +: 2], mMir[`CS_NEXT_LSB +: `CS_ADDR_W],
                               flag, mUpc) : hostAddr;
      end
   end

   // compare at the falling edge where every output is settled
   always @(negedge clk) begin
      int sel;
      logic [`CS_SLICE_W-1:0] expBus;
      sel = lowSlice(ewN);
      expBus = '0;
      if (wcsN && !ecslN && sel >= 0) expBus = mMir[sel*`CS_SLICE_W +: `CS_SLICE_W];
      checkCount++;
      assert (uPC === mUpc) else valueError("uPC", 64'(mUpc), 64'(uPC));
      // words never written are skipped
      if (mMirKnown) begin
         assert (ctrlBits === mMir[`CS_CTRL_LSB +: `CS_CTRL_W])
            else valueError("ctrlBits", 64'(mMir[`CS_CTRL_LSB +: `CS_CTRL_W]), 64'(ctrlBits));
         assert (idbOut === expBus) else valueError("idbOut", 64'(expBus), 64'(idbOut));
      end
      if (holdArmed) begin
         holdSeen++;
         assert (uPC === holdUpc) else valueError("uPC under hold", 64'(holdUpc), 64'(uPC));
      end
      holdArmed = rstN && run && mMirKnown && (mMir[`CS_SEQOP_LSB +: 2] == 2'd3);
      holdUpc = uPC;
   end

   // four one-hot slice strobes and then a commit at addr
   task automatic writeWord(input logic [7:0] addr, input logic [63:0] word);
      for (int i = 0; i < 4; i++) begin
         @(posedge clk);
         wcsN <= 1'b0;
         ewN <= ~(4'b0001 << i);
         idbIn <= word[i*`CS_SLICE_W +: `CS_SLICE_W];
      end
      @(posedge clk);
      wcsN <= 1'b1;
      ewN <= 4'hf;
      hostAddr <= addr;
      wcsCommit <= 1'b1;
      @(posedge clk);
      wcsCommit <= 1'b0;
   endtask

   task automatic busCheck(input logic [3:0] en, input logic oeN, input logic wrN,
                           input logic [15:0] expBus);
      @(posedge clk);
      ewN <= en;
      ecslN <= oeN;
      wcsN <= wrN;
      @(negedge clk);
      assert (idbOut === expBus) else valueError("bus slice", 64'(expBus), 64'(idbOut));
   endtask

   // word reaches the MIR three edges after hostAddr changes
   task automatic readWord(input logic [7:0] addr, input logic [63:0] word);
      @(posedge clk);
      hostAddr <= addr;
      repeat (2) @(posedge clk);
      for (int i = 0; i < 4; i++) begin
         busCheck(~(4'b0001 << i), 1'b0, 1'b1, word[i*`CS_SLICE_W +: `CS_SLICE_W]);
      end
   endtask

   initial begin
      logic [63:0] r;
      logic [63:0] w;
      rstN = 1'b0;
      run = 1'b0;
      hostAddr = '0;
      idbIn = '0;
      wcsN = 1'b1;
      ewN = 4'hf;
      ecslN = 1'b1;
      wcsCommit = 1'b0;
      flag = 1'b0;
      repeat (3) @(posedge clk);
      rstN <= 1'b1;
      @(negedge clk);
      assert (uPC === '0) else valueError("uPC after reset", 64'h0, 64'(uPC));
      assert (ctrlBits === '0) else valueError("ctrlBits after reset", 64'h0, 64'(ctrlBits));
      assert (idbOut === '0) else valueError("idbOut after reset", 64'h0, 64'(idbOut));

      // random words to distinct random addresses and then read back
      for (int k = 0; k < TEST_WORDS; k++) begin
         takeBits(4, r);
         testAddr[k] = {r[3:0], 4'(k)};
         takeBits(64, testWord[k]);
         writeWord(testAddr[k], testWord[k]);
      end
      for (int k = 0; k < TEST_WORDS; k++) begin
         readWord(testAddr[k], testWord[k]);
      end

      // with several enables low only the lowest slice of staging changes
      takeBits(32, r);
      w = {testWord[TEST_WORDS-1][63:32], r[31:0]};
      @(posedge clk);
      wcsN <= 1'b0;
      ewN <= 4'b0110;
      idbIn <= r[15:0];
      @(posedge clk);
      ewN <= 4'b1001;
      idbIn <= r[31:16];
      @(posedge clk);
      wcsN <= 1'b1;
      ewN <= 4'hf;
      hostAddr <= testAddr[0];
      wcsCommit <= 1'b1;
      @(posedge clk);
      wcsCommit <= 1'b0;
      readWord(testAddr[0], w);
      busCheck(4'b0100, 1'b0, 1'b1, w[15:0]);
      busCheck(4'b1001, 1'b0, 1'b1, w[31:16]);
      // output enable off, no slice, write direction
      busCheck(4'b0000, 1'b1, 1'b1, 16'h0000);
      busCheck(4'b1111, 1'b0, 1'b1, 16'h0000);
      busCheck(4'b1011, 1'b0, 1'b0, 16'h0000);
      busCheck(4'b1111, 1'b1, 1'b1, 16'h0000);

      // whole store gets a program of next, jump and conditional jump words
      for (int a = 0; a < `CS_DEPTH; a++) begin
         takeBits(64, w);
         if (w[`CS_SEQOP_LSB +: 2] == 2'd3) w[`CS_SEQOP_LSB +: 2] = 2'd0;
         writeWord(8'(a), w);
      end
      @(posedge clk);
      hostAddr <= '0;
      repeat (3) @(posedge clk);
      run <= 1'b1;
      repeat (RUN_CYCLES) begin
         @(posedge clk);
         takeBits(1, r);
         flag <= r[0];
      end
      @(posedge clk);
      run <= 1'b0;

      // hold word at a random address stops the sequencer there
      takeBits(8, r);
      takeBits(64, w);
      w[`CS_SEQOP_LSB +: 2] = 2'd3;
      writeWord(r[7:0], w);
      repeat (3) @(posedge clk);
      run <= 1'b1;
      repeat (HOLD_CYCLES) @(posedge clk);
      run <= 1'b0;
      @(negedge clk);
      assert (holdSeen > 0) else begin
         errCount++;
         $display("the hold word never reached the MIR while running");
      end

      $display("checks: %0d, errors: %0d", checkCount, errCount);
      if (errCount == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   // bound on the whole run
   initial begin
      #(LIMIT_CYCLES * CLK_PERIOD);
      $display("watchdog expired before the test sequence finished");
      $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- controlStoreTop.f
+incdir+design
design/csPkg.sv
design/microSequencer.sv
design/controlStoreRam.sv
design/microWordRegister.sv
design/csTransceiver.sv
design/controlStoreTop.sv
verif/controlStoreTb.sv

//--- run.sh
#!/bin/sh
# build and run the control store testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ns \
   --top-module controlStoreTb -f controlStoreTop.f -o controlStoreSim

./obj_dir/controlStoreSim | tee sim.log

# the testbench reports its verdict in the log
if grep -q "tests failed" sim.log; then
   echo "simulation reported a failure, see sim.log"
   exit 1
fi
echo "simulation finished cleanly"
